/* hw/mem_bridge_pkg.sv */
package mem_bridge_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int LINE_WORDS = 4;
    localparam int LINE_W     = LINE_WORDS * DATA_W;
    localparam int ID_W       = 4;
    localparam int LEN_W      = 4;
    localparam int SIZE_W     = 3;
    localparam int BURST_W    = 2;
    localparam int RESP_W     = 2;

    // Fixed AXI field values
    localparam logic [ID_W-1:0]    INST_ID    = 4'd0;
    localparam logic [ID_W-1:0]    DATA_ID    = 4'd1;
    localparam logic [LEN_W-1:0]   INST_LEN   = 4'd3;
    localparam logic [SIZE_W-1:0]  WORD_SIZE  = 3'd2;
    localparam logic [BURST_W-1:0] BURST_INCR = 2'd1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDR_READ,
        ST_DATA_READ,
        ST_ADDR_WRITE,
        ST_WRITE_RESP
    } access_state_e;

    typedef enum logic {
        CLIENT_INST,
        CLIENT_DATA
    } client_e;

    typedef struct packed {
        logic              wr;
        logic [1:0]        size;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
    } data_req_t;

    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [ADDR_W-1:0]  addr;
        logic [LEN_W-1:0]   len;
        logic [SIZE_W-1:0]  size;
        logic [BURST_W-1:0] burst;
    } axi_ar_t;

    // Write address carries the same fields as read address
    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [RESP_W-1:0] resp;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [RESP_W-1:0] resp;
    } axi_b_t;

endpackage

/* hw/port_arbiter.sv */
`timescale 1ns/1ns
module port_arbiter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    inst_req,
    input  logic                    data_req,
    input  logic                    start,
    output mem_bridge_pkg::client_e grant,
    output logic                    grant_valid
);

    mem_bridge_pkg::client_e last_winner;

    // Tie goes to whoever lost last time
    always_comb begin
        if (inst_req && data_req) begin
            grant = (last_winner == mem_bridge_pkg::CLIENT_INST) ?
                    mem_bridge_pkg::CLIENT_DATA : mem_bridge_pkg::CLIENT_INST;
        end else if (data_req) begin
            grant = mem_bridge_pkg::CLIENT_DATA;
        end else begin
            grant = mem_bridge_pkg::CLIENT_INST;
        end
    end

    assign grant_valid = inst_req | data_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_winner <= mem_bridge_pkg::CLIENT_INST;
        end else if (start) begin
            last_winner <= grant;
        end
    end

    start_needs_request: assert property (
        @(posedge clk) disable iff (!rst_n) start |-> grant_valid
    );

endmodule

/* hw/access_fsm.sv */
`timescale 1ns/1ns
module access_fsm (
    input  logic                              clk,
    input  logic                              rst_n,
    input  mem_bridge_pkg::client_e           grant,
    input  logic                              grant_valid,
    input  mem_bridge_pkg::data_req_t         data_cmd,
    input  logic [mem_bridge_pkg::ADDR_W-1:0] inst_addr,
    input  logic                              arready,
    input  logic                              awready,
    input  logic                              wready,
    input  logic                              rvalid,
    input  logic                              bvalid,
    input  logic                              r_last,
    input  logic                              beat_last,
    output logic                              start,
    output mem_bridge_pkg::axi_ar_t           ar,
    output logic                              arvalid,
    output mem_bridge_pkg::axi_aw_t           aw,
    output mem_bridge_pkg::axi_w_t            w,
    output logic                              awvalid,
    output logic                              wvalid,
    output logic                              rready,
    output logic                              bready,
    output logic                              inst_addr_ok,
    output logic                              data_addr_ok,
    output logic                              inst_data_ok,
    output logic                              data_data_ok
);

    mem_bridge_pkg::access_state_e state;
    mem_bridge_pkg::access_state_e state_next;
    mem_bridge_pkg::client_e       owner;
    mem_bridge_pkg::axi_ar_t       addr_next;
    mem_bridge_pkg::axi_ar_t       addr_q;
    logic                          aw_done;
    logic                          w_done;
    logic                          done;
    logic                          aw_fire;
    logic                          w_fire;
    logic                          read_end;
    logic                          write_end;

    assign start        = (state == mem_bridge_pkg::ST_IDLE) && grant_valid;
    assign inst_addr_ok = start && (grant == mem_bridge_pkg::CLIENT_INST);
    assign data_addr_ok = start && (grant == mem_bridge_pkg::CLIENT_DATA);

    assign arvalid = (state == mem_bridge_pkg::ST_ADDR_READ);
    assign rready  = (state == mem_bridge_pkg::ST_DATA_READ);
    assign awvalid = (state == mem_bridge_pkg::ST_ADDR_WRITE) && !aw_done;
    assign wvalid  = (state == mem_bridge_pkg::ST_ADDR_WRITE) && !w_done;
    assign bready  = (state == mem_bridge_pkg::ST_WRITE_RESP);

    assign aw_fire   = awvalid && awready;
    assign w_fire    = wvalid && wready;
    assign read_end  = rready && rvalid && r_last;
    assign write_end = bready && bvalid;

    assign ar = addr_q;
    assign aw = addr_q;

    assign inst_data_ok = done && (owner == mem_bridge_pkg::CLIENT_INST);
    assign data_data_ok = done && (owner == mem_bridge_pkg::CLIENT_DATA);

    // Fetch is a four-beat burst, data is always one beat
    always_comb begin
        addr_next.burst = mem_bridge_pkg::BURST_INCR;
        if (grant == mem_bridge_pkg::CLIENT_INST) begin
            addr_next.id   = mem_bridge_pkg::INST_ID;
            addr_next.addr = inst_addr;
            addr_next.len  = mem_bridge_pkg::INST_LEN;
            addr_next.size = mem_bridge_pkg::WORD_SIZE;
        end else begin
            addr_next.id   = mem_bridge_pkg::DATA_ID;
            addr_next.addr = data_cmd.addr;
            addr_next.len  = '0;
            addr_next.size = {1'b0, data_cmd.size};
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            mem_bridge_pkg::ST_IDLE: begin
                if (start && grant == mem_bridge_pkg::CLIENT_DATA && data_cmd.wr) begin
                    state_next = mem_bridge_pkg::ST_ADDR_WRITE;
                end else if (start) begin
                    state_next = mem_bridge_pkg::ST_ADDR_READ;
                end
            end
            mem_bridge_pkg::ST_ADDR_READ: begin
                if (arready) begin
                    state_next = mem_bridge_pkg::ST_DATA_READ;
                end
            end
            mem_bridge_pkg::ST_DATA_READ: begin
                if (read_end) begin
                    state_next = mem_bridge_pkg::ST_IDLE;
                end
            end
            mem_bridge_pkg::ST_ADDR_WRITE: begin
                // AW and W may be accepted in either order
                if ((aw_done || aw_fire) && (w_done || w_fire)) begin
                    state_next = mem_bridge_pkg::ST_WRITE_RESP;
                end
            end
            mem_bridge_pkg::ST_WRITE_RESP: begin
                if (write_end) begin
                    state_next = mem_bridge_pkg::ST_IDLE;
                end
            end
            default: state_next = mem_bridge_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= mem_bridge_pkg::ST_IDLE;
            owner   <= mem_bridge_pkg::CLIENT_INST;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            done    <= 1'b0;
        end else begin
            state <= state_next;
            done  <= read_end || write_end;
            if (start) begin
                owner   <= grant;
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end else begin
                if (aw_fire) begin
                    aw_done <= 1'b1;
                end
                if (w_fire) begin
                    w_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= addr_next;
            w      <= '{data: data_cmd.wdata, strb: data_cmd.wstrb, last: 1'b1};
        end
    end

    ar_held: assert property (
        @(posedge clk) disable iff (!rst_n) arvalid && !arready |=> $stable(ar)
    );

    // Slave's last flag must agree with our own beat count
    last_beat_agrees: assert property (
        @(posedge clk) disable iff (!rst_n) rvalid && rready |-> r_last == beat_last
    );

endmodule

/* hw/beat_counter.sv */
`timescale 1ns/1ns
module beat_counter (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  logic [mem_bridge_pkg::LEN_W-1:0] expected_len,
    input  logic                             beat_fire,
    output logic [1:0]                       beat_index,
    output logic                             beat_last
);

    logic [mem_bridge_pkg::LEN_W-1:0] count;

    // Length is the AXI len field, so a single beat has length 0
    assign beat_last  = (count == expected_len);
    assign beat_index = count[1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (start) begin
            count <= '0;
        end else if (beat_fire) begin
            count <= count + 1'b1;
        end
    end

    // A beat past the last would find the count above the length
    count_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) beat_fire |-> count <= expected_len
    );

endmodule

/* hw/line_buffer.sv */
`timescale 1ns/1ns
module line_buffer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              beat_fire,
    input  logic [1:0]                        beat_index,
    input  logic [mem_bridge_pkg::DATA_W-1:0] beat_data,
    output logic [mem_bridge_pkg::LINE_W-1:0] line,
    output logic [mem_bridge_pkg::DATA_W-1:0] word
);

    logic [mem_bridge_pkg::LINE_WORDS-1:0][mem_bridge_pkg::DATA_W-1:0] slots;

    // Word 0 of the line sits in the low bits
    assign line = slots;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slots <= '0;
            word  <= '0;
        end else if (beat_fire) begin
            slots[beat_index] <= beat_data;
            word              <= beat_data;
        end
    end

endmodule

/* hw/mem_bridge_top.sv */
`timescale 1ns/1ns
module mem_bridge_top (
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              inst_req,
    input  logic [mem_bridge_pkg::ADDR_W-1:0] inst_addr,
    output logic                              inst_addr_ok,
    output logic                              inst_data_ok,
    output logic [mem_bridge_pkg::LINE_W-1:0] inst_rdata,

    input  logic                              data_req,
    input  mem_bridge_pkg::data_req_t         data_cmd,
    output logic                              data_addr_ok,
    output logic                              data_data_ok,
    output logic [mem_bridge_pkg::DATA_W-1:0] data_rdata,

    output mem_bridge_pkg::axi_ar_t           ar,
    output logic                              arvalid,
    input  logic                              arready,
    input  mem_bridge_pkg::axi_r_t            r,
    input  logic                              rvalid,
    output logic                              rready,
    output mem_bridge_pkg::axi_aw_t           aw,
    output logic                              awvalid,
    input  logic                              awready,
    output mem_bridge_pkg::axi_w_t            w,
    output logic                              wvalid,
    input  logic                              wready,
    input  mem_bridge_pkg::axi_b_t            b,
    input  logic                              bvalid,
    output logic                              bready
);

    mem_bridge_pkg::client_e grant;
    logic                    grant_valid;
    logic                    start;
    logic                    beat_fire;
    logic                    beat_last;
    logic [1:0]              beat_index;

    assign beat_fire = rvalid && rready;

    port_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_req    (inst_req),
        .data_req    (data_req),
        .start       (start),
        .grant       (grant),
        .grant_valid (grant_valid)
    );

    access_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .grant        (grant),
        .grant_valid  (grant_valid),
        .data_cmd     (data_cmd),
        .inst_addr    (inst_addr),
        .arready      (arready),
        .awready      (awready),
        .wready       (wready),
        .rvalid       (rvalid),
        .bvalid       (bvalid),
        .r_last       (r.last),
        .beat_last    (beat_last),
        .start        (start),
        .ar           (ar),
        .arvalid      (arvalid),
        .aw           (aw),
        .w            (w),
        .awvalid      (awvalid),
        .wvalid       (wvalid),
        .rready       (rready),
        .bready       (bready),
        .inst_addr_ok (inst_addr_ok),
        .data_addr_ok (data_addr_ok),
        .inst_data_ok (inst_data_ok),
        .data_data_ok (data_data_ok)
    );

    // AR stays stable for the whole read, so its len bounds the count
    beat_counter u_counter (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .expected_len (ar.len),
        .beat_fire    (beat_fire),
        .beat_index   (beat_index),
        .beat_last    (beat_last)
    );

    line_buffer u_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_fire  (beat_fire),
        .beat_index (beat_index),
        .beat_data  (r.data),
        .line       (inst_rdata),
        .word       (data_rdata)
    );

    // Only one transaction in flight, so returned ids echo the request
    r_id_matches: assert property (
        @(posedge clk) disable iff (!rst_n) beat_fire |-> r.id == ar.id
    );

    b_id_matches: assert property (
        @(posedge clk) disable iff (!rst_n)
        bvalid && bready |-> b.id == mem_bridge_pkg::DATA_ID
    );

endmodule

/* dv/axi_mem_model.sv */
`timescale 1ns/1ns
module axi_mem_model (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mem_bridge_pkg::axi_ar_t ar,
    input  logic                    arvalid,
    output logic                    arready,
    output mem_bridge_pkg::axi_r_t  r,
    output logic                    rvalid,
    input  logic                    rready,
    input  mem_bridge_pkg::axi_aw_t aw,
    input  logic                    awvalid,
    output logic                    awready,
    input  mem_bridge_pkg::axi_w_t  w,
    input  logic                    wvalid,
    output logic                    wready,
    output mem_bridge_pkg::axi_b_t  b,
    output logic                    bvalid,
    input  logic                    bready
);

    integer seed = 32'hd2db_9cef;

    // Only written words are stored, the rest read as the inverted address
    logic [mem_bridge_pkg::DATA_W-1:0] mem [logic [mem_bridge_pkg::ADDR_W-3:0]];

    logic [mem_bridge_pkg::ADDR_W-1:0] rd_addr;
    logic [mem_bridge_pkg::LEN_W-1:0]  rd_left;
    logic [mem_bridge_pkg::ID_W-1:0]   rd_id;
    logic                              rd_busy;
    mem_bridge_pkg::axi_aw_t           aw_q;
    mem_bridge_pkg::axi_w_t            w_q;
    logic                              aw_got;
    logic                              w_got;
    logic [1:0]                        ar_wait;
    logic [1:0]                        r_wait;
    logic [1:0]                        aw_wait;
    logic [1:0]                        w_wait;
    logic [1:0]                        b_wait;

    function automatic logic [1:0] stall();
        return 2'($random(seed));
    endfunction

    function automatic logic [mem_bridge_pkg::DATA_W-1:0] load(
        input logic [mem_bridge_pkg::ADDR_W-1:0] addr
    );
        if (mem.exists(addr[mem_bridge_pkg::ADDR_W-1:2])) begin
            return mem[addr[mem_bridge_pkg::ADDR_W-1:2]];
        end
        return ~{addr[mem_bridge_pkg::ADDR_W-1:2], 2'b00};
    endfunction

    function automatic logic [mem_bridge_pkg::DATA_W-1:0] merge(
        input logic [mem_bridge_pkg::DATA_W-1:0] old,
        input mem_bridge_pkg::axi_w_t            wd
    );
        logic [mem_bridge_pkg::DATA_W-1:0] res;
        res = old;
        for (int i = 0; i < mem_bridge_pkg::STRB_W; i++) begin
            if (wd.strb[i]) begin
                res[8*i +: 8] = wd.data[8*i +: 8];
            end
        end
        return res;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            r       <= '0;
            b       <= '0;
            rd_busy <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            ar_wait <= stall();
            r_wait  <= stall();
            aw_wait <= stall();
            w_wait  <= stall();
            b_wait  <= stall();
        end else begin
            if (arvalid && arready) begin
                arready <= 1'b0;
                rd_addr <= ar.addr;
                rd_left <= ar.len;
                rd_id   <= ar.id;
                rd_busy <= 1'b1;
                ar_wait <= stall();
            end else if (arvalid && !rd_busy) begin
                if (ar_wait == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 2'd1;
                end
            end

            // One beat at a time, each after its own stall
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rd_addr <= rd_addr + 32'd4;
                rd_left <= rd_left - 4'd1;
                r_wait  <= stall();
                if (r.last) begin
                    rd_busy <= 1'b0;
                end
            end else if (rd_busy && !rvalid) begin
                if (r_wait == 2'd0) begin
                    rvalid <= 1'b1;
                    r      <= '{id: rd_id, data: load(rd_addr), resp: 2'b00,
                                last: rd_left == 4'd0};
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end

            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_q    <= aw;
                aw_got  <= 1'b1;
                aw_wait <= stall();
            end else if (awvalid && !aw_got) begin
                if (aw_wait == 2'd0) begin
                    awready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 2'd1;
                end
            end

            if (wvalid && wready) begin
                wready <= 1'b0;
                w_q    <= w;
                w_got  <= 1'b1;
                w_wait <= stall();
            end else if (wvalid && !w_got) begin
                if (w_wait == 2'd0) begin
                    wready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 2'd1;
                end
            end

            // Memory updates when the response goes out
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_wait <= stall();
            end else if (aw_got && w_got && !bvalid) begin
                if (b_wait == 2'd0) begin
                    mem[aw_q.addr[mem_bridge_pkg::ADDR_W-1:2]] = merge(load(aw_q.addr), w_q);
                    bvalid <= 1'b1;
                    b      <= '{id: aw_q.id, resp: 2'b00};
                    aw_got <= 1'b0;
                    w_got  <= 1'b0;
                end else begin
                    b_wait <= b_wait - 2'd1;
                end
            end
        end
    end

endmodule

/* dv/mem_bridge_tb.sv */
`timescale 1ns/1ns
module mem_bridge_tb;

    typedef struct packed {
        logic                              inst;
        logic                              wr;
        logic [mem_bridge_pkg::ADDR_W-1:0] addr;
        logic [mem_bridge_pkg::DATA_W-1:0] wdata;
        logic [mem_bridge_pkg::STRB_W-1:0] strb;
        logic [mem_bridge_pkg::DATA_W-1:0] exp_word;
        logic [mem_bridge_pkg::LINE_W-1:0] exp_line;
    } entry_t;

    typedef enum {
        INST_ADDR_OK,
        DATA_ADDR_OK,
        INST_DATA_OK,
        DATA_DATA_OK
    } pulse_e;

    logic                              clk;
    logic                              rst_n;
    logic                              inst_req;
    logic [mem_bridge_pkg::ADDR_W-1:0] inst_addr;
    logic                              inst_addr_ok;
    logic                              inst_data_ok;
    logic [mem_bridge_pkg::LINE_W-1:0] inst_rdata;
    logic                              data_req;
    mem_bridge_pkg::data_req_t         data_cmd;
    logic                              data_addr_ok;
    logic                              data_data_ok;
    logic [mem_bridge_pkg::DATA_W-1:0] data_rdata;
    mem_bridge_pkg::axi_ar_t           ar;
    mem_bridge_pkg::axi_ar_t           ar_seen;
    mem_bridge_pkg::axi_r_t            r;
    mem_bridge_pkg::axi_aw_t           aw;
    mem_bridge_pkg::axi_aw_t           aw_seen;
    mem_bridge_pkg::axi_w_t            w;
    mem_bridge_pkg::axi_w_t            w_seen;
    mem_bridge_pkg::axi_b_t            b;
    logic                              arvalid;
    logic                              arready;
    logic                              rvalid;
    logic                              rready;
    logic                              awvalid;
    logic                              awready;
    logic                              wvalid;
    logic                              wready;
    logic                              bvalid;
    logic                              bready;
    int                                max_wait_cycles = 200;
    entry_t                            stim [$];

    mem_bridge_top u_dut (
        .clk (clk), .rst_n (rst_n),
        .inst_req (inst_req), .inst_addr (inst_addr), .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok), .inst_rdata (inst_rdata),
        .data_req (data_req), .data_cmd (data_cmd), .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok), .data_rdata (data_rdata),
        .ar (ar), .arvalid (arvalid), .arready (arready),
        .r (r), .rvalid (rvalid), .rready (rready),
        .aw (aw), .awvalid (awvalid), .awready (awready),
        .w (w), .wvalid (wvalid), .wready (wready),
        .b (b), .bvalid (bvalid), .bready (bready)
    );

    axi_mem_model u_mem (
        .clk (clk), .rst_n (rst_n),
        .ar (ar), .arvalid (arvalid), .arready (arready),
        .r (r), .rvalid (rvalid), .rready (rready),
        .aw (aw), .awvalid (awvalid), .awready (awready),
        .w (w), .wvalid (wvalid), .wready (wready),
        .b (b), .bvalid (bvalid), .bready (bready)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (arvalid && arready) begin
            ar_seen <= ar;
        end
        if (awvalid && awready) begin
            aw_seen <= aw;
        end
        if (wvalid && wready) begin
            w_seen <= w;
        end
    end

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [mem_bridge_pkg::DATA_W-1:0] got,
                              input logic [mem_bridge_pkg::DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_line(input string name, input logic [mem_bridge_pkg::LINE_W-1:0] got,
                              input logic [mem_bridge_pkg::LINE_W-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_axi_ar(input string name, input mem_bridge_pkg::axi_ar_t got,
                                input mem_bridge_pkg::axi_ar_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_axi_w(input string name, input mem_bridge_pkg::axi_w_t got,
                               input mem_bridge_pkg::axi_w_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic pulse_seen(input pulse_e which);
        case (which)
            INST_ADDR_OK: return inst_addr_ok;
            DATA_ADDR_OK: return data_addr_ok;
            INST_DATA_OK: return inst_data_ok;
            DATA_DATA_OK: return data_data_ok;
            default:      return 1'b0;
        endcase
    endfunction

    // Called at a sample point, a quarter period after the falling edge
    task automatic wait_for_pulse(input pulse_e which);
        int cycles;
        cycles = 0;
        while (!pulse_seen(which)) begin
            if (cycles == max_wait_cycles) begin
                $display("timeout: no %s within %0d cycles", which.name(), cycles);
                stop_run();
            end
            cycles++;
            @(negedge clk);
            #5;
        end
    endtask

    // Fetch is a four-beat incrementing word burst, data is a single word
    function automatic mem_bridge_pkg::axi_ar_t expected_ar(
        input logic inst,
        input logic [mem_bridge_pkg::ADDR_W-1:0] addr
    );
        mem_bridge_pkg::axi_ar_t a;
        a.id    = inst ? 4'd0 : 4'd1;
        a.addr  = addr;
        a.len   = inst ? 4'd3 : 4'd0;
        a.size  = 3'd2;
        a.burst = 2'd1;
        return a;
    endfunction

    function automatic entry_t data_entry(input logic wr,
                                          input logic [mem_bridge_pkg::ADDR_W-1:0] addr,
                                          input logic [mem_bridge_pkg::DATA_W-1:0] wdata,
                                          input logic [mem_bridge_pkg::STRB_W-1:0] strb,
                                          input logic [mem_bridge_pkg::DATA_W-1:0] word);
        return '{inst: 1'b0, wr: wr, addr: addr, wdata: wdata, strb: strb,
                 exp_word: word, exp_line: '0};
    endfunction

    function automatic entry_t fetch_entry(input logic [mem_bridge_pkg::ADDR_W-1:0] addr,
                                           input logic [mem_bridge_pkg::LINE_W-1:0] line);
        return '{inst: 1'b1, wr: 1'b0, addr: addr, wdata: '0, strb: '0,
                 exp_word: '0, exp_line: line};
    endfunction

    task automatic fill_table();
        stim.push_back(data_entry(1'b0, 32'h0000_0100, '0, '0, ~32'h0000_0100));
        stim.push_back(data_entry(1'b1, 32'h0000_0104, 32'h1234_5678, 4'hf, '0));
        stim.push_back(data_entry(1'b0, 32'h0000_0104, '0, '0, 32'h1234_5678));
        // Bytes 0 and 2 new, bytes 1 and 3 from the inverted address
        stim.push_back(data_entry(1'b1, 32'h0000_0108, 32'haabb_ccdd, 4'b0101, '0));
        stim.push_back(data_entry(1'b0, 32'h0000_0108, '0, '0, 32'hffbb_fedd));
        stim.push_back(fetch_entry(32'h0000_0200,
            {~32'h0000_020c, ~32'h0000_0208, ~32'h0000_0204, ~32'h0000_0200}));
        stim.push_back(fetch_entry(32'h0000_0100,
            {~32'h0000_010c, 32'hffbb_fedd, 32'h1234_5678, ~32'h0000_0100}));
        stim.push_back(data_entry(1'b0, 32'h0000_020c, '0, '0, ~32'h0000_020c));
    endtask

    task automatic run_entry(input entry_t e);
        @(negedge clk);
        if (e.inst) begin
            inst_req  = 1'b1;
            inst_addr = e.addr;
        end else begin
            data_req = 1'b1;
            data_cmd = '{wr: e.wr, size: 2'd2, addr: e.addr, wdata: e.wdata, wstrb: e.strb};
        end
        #5;
        wait_for_pulse(e.inst ? INST_ADDR_OK : DATA_ADDR_OK);
        @(negedge clk);
        inst_req = 1'b0;
        data_req = 1'b0;
        #5;
        wait_for_pulse(e.inst ? INST_DATA_OK : DATA_DATA_OK);
        if (e.inst) begin
            check_line("inst_rdata", inst_rdata, e.exp_line);
            check_axi_ar("ar", ar_seen, expected_ar(1'b1, e.addr));
        end else if (!e.wr) begin
            check_word("data_rdata", data_rdata, e.exp_word);
            check_axi_ar("ar", ar_seen, expected_ar(1'b0, e.addr));
        end else begin
            check_axi_ar("aw", aw_seen, expected_ar(1'b0, e.addr));
            check_axi_w("w", w_seen, '{data: e.wdata, strb: e.strb, last: 1'b1});
        end
    endtask

    // Both clients in the same cycle right after reset, data must win
    task automatic run_tie();
        @(negedge clk);
        inst_req  = 1'b1;
        inst_addr = 32'h0000_0400;
        data_req  = 1'b1;
        data_cmd  = '{wr: 1'b0, size: 2'd2, addr: 32'h0000_0300, wdata: '0, wstrb: '0};
        #5;
        if (!data_addr_ok || inst_addr_ok) begin
            $display("data client was not granted first when both requested after reset");
            stop_run();
        end
        @(negedge clk);
        data_req = 1'b0;
        #5;
        wait_for_pulse(DATA_DATA_OK);
        check_word("data_rdata", data_rdata, ~32'h0000_0300);
        wait_for_pulse(INST_ADDR_OK);
        @(negedge clk);
        inst_req = 1'b0;
        #5;
        wait_for_pulse(INST_DATA_OK);
        check_line("inst_rdata", inst_rdata,
            {~32'h0000_040c, ~32'h0000_0408, ~32'h0000_0404, ~32'h0000_0400});
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        inst_req  = 1'b0;
        inst_addr = '0;
        data_req  = 1'b0;
        data_cmd  = '0;
        fill_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        run_tie();
        foreach (stim[i]) begin
            run_entry(stim[i]);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* all.f */
hw/mem_bridge_pkg.sv
hw/port_arbiter.sv
hw/access_fsm.sv
hw/beat_counter.sv
hw/line_buffer.sv
hw/mem_bridge_top.sv
dv/axi_mem_model.sv
dv/mem_bridge_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= mem_bridge_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
